// ==== hw/sdmac_pkg.sv ====
// widths, FIFO depth, bus-master state encoding, config and bus structs
package sdmac_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int CNT_W      = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // bus-master states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        REQ       = 3'd1,
        ADDR      = 3'd2,
        DATA      = 3'd3,
        WAIT_TERM = 3'd4,
        END_CYC   = 3'd5,
        RELEASE   = 3'd6
    } sm_state_t;

    // dir 0 moves peripheral data to memory, 1 moves memory data to the peripheral
    typedef struct packed {
        logic              dir;
        logic [ADDR_W-1:0] base;
        logic [CNT_W-1:0]  length;
    } dma_cfg_t;

    // strobes and direction from the state machine
    typedef struct packed {
        logic as_;
        logic ds_;
        logic rw;
    } bus_ctl_t;

    typedef struct packed {
        logic              as_;
        logic              ds_;
        logic              rw;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_out_t;

    typedef struct packed {
        logic [1:0]        dsack_;
        logic              sterm_;
        logic [DATA_W-1:0] rdata;
    } bus_in_t;

endpackage

// ==== hw/xfer_counter.sv ====
// address and remaining-length counter for one transfer
`timescale 1ns/1ps
module xfer_counter (
    input  logic                          BBCLK,
    input  logic                          CCRESET_,
    input  logic                          cnt_load,
    input  logic                          cnt_step,
    input  sdmac_pkg::dma_cfg_t           cfg,
    output logic [sdmac_pkg::ADDR_W-1:0]  addr,
    output logic [sdmac_pkg::CNT_W-1:0]   remaining,
    output logic                          last_word
);

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            addr      <= '0;
            remaining <= '0;
        end else if (cnt_load) begin
            addr      <= cfg.base;
            remaining <= cfg.length;
        end else if (cnt_step) begin
            // one longword per bus cycle
            addr      <= addr + sdmac_pkg::ADDR_W'(4);
            remaining <= remaining - 1'b1;
        end
    end

    assign last_word = (remaining == sdmac_pkg::CNT_W'(1));

endmodule

// ==== hw/dma_fifo.sv ====
// longword FIFO with occupancy count and full and empty flags
`timescale 1ns/1ps
module dma_fifo (
    input  logic                         BBCLK,
    input  logic                         CCRESET_,
    input  logic                         push,
    input  logic [sdmac_pkg::DATA_W-1:0] wdata,
    input  logic                         pop,
    output logic [sdmac_pkg::DATA_W-1:0] rdata,
    output logic [sdmac_pkg::FIFO_AW:0]  count,
    output logic                         full,
    output logic                         empty
);

    logic [sdmac_pkg::DATA_W-1:0]  mem [sdmac_pkg::FIFO_DEPTH];
    logic [sdmac_pkg::FIFO_AW-1:0] wr_ptr;
    logic [sdmac_pkg::FIFO_AW-1:0] rd_ptr;
    logic                          wr_en;
    logic                          rd_en;

    // strobes against a full or empty FIFO are dropped
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full  = (count == (sdmac_pkg::FIFO_AW + 1)'(sdmac_pkg::FIFO_DEPTH));
    assign empty = (count == '0);
    assign rdata = mem[rd_ptr];

    always_ff @(posedge BBCLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/cpu_sm.sv ====
// bus-master FSM with input registering, bus arbitration and bus cycle sequencing
`timescale 1ns/1ps
module cpu_sm (
    input  logic                         BBCLK,
    input  logic                         CCRESET_,
    input  logic                         dreq_,
    input  logic                         bgrant_,
    input  logic                         flush,
    input  logic                         dma_ena,
    input  logic                         dir,
    input  sdmac_pkg::bus_in_t           bus_i,
    input  logic [sdmac_pkg::FIFO_AW:0]  fifo_count,
    input  logic                         fifo_full,
    input  logic                         fifo_empty,
    input  logic [sdmac_pkg::CNT_W-1:0]  remaining,
    output logic                         breq_,
    output logic                         bgack_,
    output sdmac_pkg::bus_ctl_t          bus_ctl,
    output logic                         fifo_pop,
    output logic                         fifo_push_bus,
    output logic [sdmac_pkg::DATA_W-1:0] rdata_cap,
    output logic                         cnt_load,
    output logic                         cnt_step,
    output logic                         stop_flush,
    output logic                         done
);

    sdmac_pkg::sm_state_t state;
    sdmac_pkg::sm_state_t next_state;
    logic dreq_r;
    logic bgrant_r;
    logic flush_r;
    logic flush_q;
    logic ena_r;
    logic ena_q;
    logic term_r;
    logic flush_pend;
    logic rem_zero;
    logic start_p2m;
    logic start_m2p;
    logic start;
    logic stop_tenure;
    logic term_hit;
    logic in_tenure;

    // asynchronous inputs are sampled once, termination sampled with them
    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dreq_r   <= 1'b1;
            bgrant_r <= 1'b1;
            flush_r  <= 1'b0;
            flush_q  <= 1'b0;
            ena_r    <= 1'b0;
            ena_q    <= 1'b0;
            term_r   <= 1'b0;
        end else begin
            dreq_r   <= dreq_;
            bgrant_r <= bgrant_;
            flush_r  <= flush;
            flush_q  <= flush_r;
            ena_r    <= dma_ena;
            ena_q    <= ena_r;
            term_r   <= !bus_i.sterm_ || (bus_i.dsack_ == 2'b00);
        end
    end

    // read data taken on the same edge as the termination sample
    always_ff @(posedge BBCLK) begin
        rdata_cap <= bus_i.rdata;
    end

    assign rem_zero = (remaining == '0);

    // P2M waits for half a FIFO, the tail of the transfer, or a flush
    assign start_p2m = !dir && !rem_zero &&
                       ((fifo_count >= (sdmac_pkg::FIFO_AW + 1)'(sdmac_pkg::FIFO_DEPTH / 2)) ||
                        (remaining == sdmac_pkg::CNT_W'(fifo_count)) ||
                        (flush_pend && !fifo_empty));
    // peripheral asks for data and the FIFO has run dry
    assign start_m2p = dir && !rem_zero && fifo_empty && !dreq_r;

    // ena_q keeps the load cycle out, remaining is stale there
    assign start = ena_r && ena_q && !done && (start_p2m || start_m2p);

    assign stop_tenure = rem_zero || (dir ? fifo_full : fifo_empty);

    assign term_hit      = (state == sdmac_pkg::WAIT_TERM) && term_r;
    assign fifo_pop      = term_hit && !dir;
    assign fifo_push_bus = term_hit && dir;
    assign cnt_step      = term_hit;
    assign cnt_load      = ena_r && !ena_q;
    assign stop_flush    = (state == sdmac_pkg::RELEASE) && flush_pend && fifo_empty;

    always_comb begin
        next_state = state;
        case (state)
            sdmac_pkg::IDLE: begin
                if (start) begin
                    next_state = sdmac_pkg::REQ;
                end else if (flush_pend && fifo_empty) begin
                    next_state = sdmac_pkg::RELEASE;
                end
            end
            sdmac_pkg::REQ: begin
                if (!bgrant_r) begin
                    next_state = sdmac_pkg::ADDR;
                end
            end
            // every cycle starts here, so back-pressure is checked once per cycle
            sdmac_pkg::ADDR: begin
                next_state = stop_tenure ? sdmac_pkg::RELEASE : sdmac_pkg::DATA;
            end
            sdmac_pkg::DATA:      next_state = sdmac_pkg::WAIT_TERM;
            sdmac_pkg::WAIT_TERM: begin
                if (term_r) begin
                    next_state = sdmac_pkg::END_CYC;
                end
            end
            sdmac_pkg::END_CYC:   next_state = sdmac_pkg::ADDR;
            sdmac_pkg::RELEASE:   next_state = sdmac_pkg::IDLE;
            default:              next_state = sdmac_pkg::IDLE;
        endcase
    end

    assign in_tenure = (state == sdmac_pkg::ADDR) || (state == sdmac_pkg::DATA) ||
                       (state == sdmac_pkg::WAIT_TERM) || (state == sdmac_pkg::END_CYC);

    assign breq_       = (state != sdmac_pkg::REQ);
    assign bgack_      = !in_tenure;
    assign bus_ctl.as_ = !((state == sdmac_pkg::DATA) || (state == sdmac_pkg::WAIT_TERM));
    assign bus_ctl.ds_ = (state != sdmac_pkg::WAIT_TERM);
    assign bus_ctl.rw  = in_tenure ? dir : 1'b1;

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state      <= sdmac_pkg::IDLE;
            flush_pend <= 1'b0;
            done       <= 1'b0;
        end else begin
            state <= next_state;
            if (flush_r && !flush_q) begin
                flush_pend <= 1'b1;
            end else if (stop_flush) begin
                flush_pend <= 1'b0;
            end
            if (!ena_r) begin
                done <= 1'b0;
            end else if ((state == sdmac_pkg::RELEASE) && rem_zero) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/dma_top.sv ====
// DMA bus-master top level joining the FSM, transfer counter and FIFO
`timescale 1ns/1ps
module dma_top (
    input  logic                         BBCLK,
    input  logic                         CCRESET_,
    input  sdmac_pkg::dma_cfg_t          cfg,
    input  logic                         dma_ena,
    input  logic                         dreq_,
    input  logic                         flush,
    input  logic                         per_wr,
    input  logic [sdmac_pkg::DATA_W-1:0] per_wdata,
    input  logic                         per_rd,
    output logic [sdmac_pkg::DATA_W-1:0] per_rdata,
    output logic                         fifo_full,
    output logic                         fifo_empty,
    output logic                         breq_,
    input  logic                         bgrant_,
    output logic                         bgack_,
    output sdmac_pkg::bus_out_t          bus_o,
    input  sdmac_pkg::bus_in_t           bus_i,
    output logic [sdmac_pkg::CNT_W-1:0]  remaining,
    output logic                         done,
    output logic                         stop_flush
);

    sdmac_pkg::bus_ctl_t          bus_ctl;
    logic                         fifo_pop;
    logic                         fifo_push_bus;
    logic [sdmac_pkg::DATA_W-1:0] rdata_cap;
    logic                         cnt_load;
    logic                         cnt_step;
    logic [sdmac_pkg::ADDR_W-1:0] addr;
    logic [sdmac_pkg::FIFO_AW:0]  fifo_count;
    logic                         push;
    logic                         pop;
    logic [sdmac_pkg::DATA_W-1:0] push_data;

    // direction picks which side fills the FIFO and which side drains it
    assign push      = cfg.dir ? fifo_push_bus : per_wr;
    assign pop       = cfg.dir ? per_rd : fifo_pop;
    assign push_data = cfg.dir ? rdata_cap : per_wdata;

    assign bus_o.as_   = bus_ctl.as_;
    assign bus_o.ds_   = bus_ctl.ds_;
    assign bus_o.rw    = bus_ctl.rw;
    assign bus_o.addr  = addr;
    assign bus_o.wdata = per_rdata;

    cpu_sm i_cpu_sm (
        .BBCLK         (BBCLK),
        .CCRESET_      (CCRESET_),
        .dreq_         (dreq_),
        .bgrant_       (bgrant_),
        .flush         (flush),
        .dma_ena       (dma_ena),
        .dir           (cfg.dir),
        .bus_i         (bus_i),
        .fifo_count    (fifo_count),
        .fifo_full     (fifo_full),
        .fifo_empty    (fifo_empty),
        .remaining     (remaining),
        .breq_         (breq_),
        .bgack_        (bgack_),
        .bus_ctl       (bus_ctl),
        .fifo_pop      (fifo_pop),
        .fifo_push_bus (fifo_push_bus),
        .rdata_cap     (rdata_cap),
        .cnt_load      (cnt_load),
        .cnt_step      (cnt_step),
        .stop_flush    (stop_flush),
        .done          (done)
    );

    xfer_counter i_xfer_counter (
        .BBCLK     (BBCLK),
        .CCRESET_  (CCRESET_),
        .cnt_load  (cnt_load),
        .cnt_step  (cnt_step),
        .cfg       (cfg),
        .addr      (addr),
        .remaining (remaining),
        .last_word ()
    );

    dma_fifo i_dma_fifo (
        .BBCLK    (BBCLK),
        .CCRESET_ (CCRESET_),
        .push     (push),
        .wdata    (push_data),
        .pop      (pop),
        .rdata    (per_rdata),
        .count    (fifo_count),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

endmodule

// ==== bench/dma_tb.sv ====
// testbench for dma_top with bus arbiter, memory responder, bus monitor and directed tests
`timescale 1ns/1ps
module dma_tb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                         BBCLK;
    logic                         CCRESET_;
    sdmac_pkg::dma_cfg_t          cfg;
    logic                         dma_ena;
    logic                         dreq_;
    logic                         flush;
    logic                         per_wr;
    logic [31:0]                  per_wdata;
    logic                         per_rd;
    logic [31:0]                  per_rdata;
    logic                         fifo_full;
    logic                         fifo_empty;
    logic                         breq_;
    logic                         bgrant_ = 1'b1;
    logic                         bgack_;
    sdmac_pkg::bus_out_t          bus_o;
    sdmac_pkg::bus_in_t           bus_i = {2'b11, 1'b1, 32'h0};
    logic [15:0]                  remaining;
    logic                         done;
    logic                         stop_flush;

    logic [15:0]         lfsr_state = 16'd44492;
    logic [31:0]         mem [64];
    logic [31:0]         words [32];
    string               test_name = "reset";
    int                  cycle_cnt = 0;
    sdmac_pkg::bus_out_t bus_s = {1'b1, 1'b1, 1'b1, 64'h0};
    logic                breq_s = 1'b1;
    logic                bgack_s = 1'b1;
    logic                prev_as = 1'b1;
    logic                prev_ds = 1'b1;
    int                  as_run = 0;
    int                  cycles_done = 0;
    int                  stop_cnt = 0;
    logic [31:0]         mon_base = '0;
    logic                arb_busy;
    logic [2:0]          arb_cnt;
    logic                resp_busy;
    logic                resp_acked;
    logic [1:0]          resp_cnt;

    dma_top i_dma_top (
        .BBCLK(BBCLK), .CCRESET_(CCRESET_), .cfg(cfg), .dma_ena(dma_ena), .dreq_(dreq_),
        .flush(flush), .per_wr(per_wr), .per_wdata(per_wdata), .per_rd(per_rd),
        .per_rdata(per_rdata), .fifo_full(fifo_full), .fifo_empty(fifo_empty),
        .breq_(breq_), .bgrant_(bgrant_), .bgack_(bgack_), .bus_o(bus_o), .bus_i(bus_i),
        .remaining(remaining), .done(done), .stop_flush(stop_flush)
    );

    initial begin
        BBCLK = 1'b0;
        forever #2 BBCLK = ~BBCLK;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hC0DE_0000 | (32'(idx) * 32'h0000_0101);
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped on failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error in %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "check mismatch");
        end
    endtask

    always @(posedge BBCLK) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now("Timeout: the run did not finish within the cycle limit");
        end
    end

    // bus sampled mid-cycle for the models to act on at the next rising edge
    always @(negedge BBCLK) begin
        bus_s   = bus_o;
        breq_s  = breq_;
        bgack_s = bgack_;
        if (CCRESET_) begin
            if (!bus_o.as_ && prev_as) begin
                check_eq(test_name, mon_base + 32'(4 * cycles_done), bus_o.addr);
                // a cycle may only start with room in the FIFO
                check_eq(test_name, 32'h0, 32'(cfg.dir ? fifo_full : fifo_empty));
                // reads fetch for the peripheral, writes store to memory
                check_eq(test_name, 32'(cfg.dir), 32'(bus_o.rw));
            end
            if (bus_o.as_ && !prev_as) begin
                cycles_done++;
            end
            if (!bus_o.ds_ && prev_ds) begin
                check_eq(test_name, 32'd1, 32'(as_run));
            end
            if (!bgack_ && bgrant_) begin
                fail_now("Bus protocol failure: bgack_ is low without a bus grant");
            end
            if (stop_flush) begin
                stop_cnt++;
            end
        end
        as_run  = bus_o.as_ ? 0 : as_run + 1;
        prev_as = bus_o.as_;
        prev_ds = bus_o.ds_;
    end

    // arbiter holds the grant until the master gives up the bus
    always @(posedge BBCLK) begin
        if (!CCRESET_) begin
            bgrant_  <= 1'b1;
            arb_busy <= 1'b0;
            arb_cnt  <= '0;
        end else if (!bgrant_) begin
            if (breq_s && bgack_s) begin
                bgrant_ <= 1'b1;
            end
        end else if (!breq_s) begin
            if (!arb_busy) begin
                arb_cnt  <= 3'(rand_bits(3));
                arb_busy <= 1'b1;
            end else if (arb_cnt == 3'd0) begin
                bgrant_  <= 1'b0;
                arb_busy <= 1'b0;
            end else begin
                arb_cnt <= arb_cnt - 3'd1;
            end
        end
    end

    task automatic answer_cycle();
        if (bus_s.rw) begin
            bus_i.rdata <= mem[bus_s.addr[7:2]];
        end else begin
            mem[bus_s.addr[7:2]] = bus_s.wdata;
        end
        if (rand_bits(1) != 32'h0) begin
            bus_i.sterm_ <= 1'b0;
        end else begin
            bus_i.dsack_ <= 2'b00;
        end
        resp_acked <= 1'b1;
    endtask

    always @(posedge BBCLK) begin
        if (!CCRESET_) begin
            resp_busy  <= 1'b0;
            resp_acked <= 1'b0;
            resp_cnt   <= '0;
        end else if (bus_s.as_) begin
            bus_i.dsack_ <= 2'b11;
            bus_i.sterm_ <= 1'b1;
            resp_busy    <= 1'b0;
            resp_acked   <= 1'b0;
        end else if (!bus_s.ds_ && !resp_acked) begin
            if (!resp_busy) begin
                resp_cnt  <= 2'(rand_bits(2));
                resp_busy <= 1'b1;
            end else if (resp_cnt == 2'd0) begin
                answer_cycle();
            end else begin
                resp_cnt <= resp_cnt - 2'd1;
            end
        end
    end

    task automatic start_xfer(input logic dir, input logic [31:0] base, input logic [15:0] len);
        @(posedge BBCLK);
        cfg         <= {dir, base, len};
        dma_ena     <= 1'b1;
        dreq_       <= 1'b0;
        mon_base    = base;
        cycles_done = 0;
        repeat (3) @(posedge BBCLK);
    endtask

    task automatic stop_xfer();
        @(posedge BBCLK);
        dma_ena <= 1'b0;
        dreq_   <= 1'b1;
        repeat (4) @(posedge BBCLK);
    endtask

    task automatic push_word(input logic [31:0] w);
        @(negedge BBCLK);
        while (fifo_full) @(negedge BBCLK);
        @(posedge BBCLK);
        per_wr    <= 1'b1;
        per_wdata <= w;
        @(posedge BBCLK);
        per_wr <= 1'b0;
    endtask

    task automatic pop_words(input int first, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge BBCLK);
            while (fifo_empty) @(negedge BBCLK);
            check_eq(test_name, mem[first + i], per_rdata);
            @(posedge BBCLK);
            per_rd <= 1'b1;
            @(posedge BBCLK);
            per_rd <= 1'b0;
        end
    endtask

    task automatic wait_done();
        @(negedge BBCLK);
        while (!done) @(negedge BBCLK);
    endtask

    task automatic reset_defaults();
        test_name = "reset";
        for (int i = 0; i < 20; i++) begin
            @(negedge BBCLK);
            check_eq(test_name, 32'hF, 32'({breq_, bgack_, bus_o.as_, bus_o.ds_}));
            check_eq(test_name, 32'h1, 32'({done, stop_flush, fifo_empty}));
        end
    endtask

    task automatic write_to_memory();
        test_name = "peripheral to memory";
        start_xfer(1'b0, 32'h40, 16'd12);
        for (int i = 0; i < 12; i++) begin
            words[i] = rand_bits(32);
            push_word(words[i]);
        end
        wait_done();
        for (int i = 0; i < 12; i++) begin
            check_eq(test_name, words[i], mem[16 + i]);
        end
        check_eq(test_name, 32'h0, 32'(remaining));
        check_eq(test_name, 32'h1, 32'(bgack_));
        check_eq(test_name, 32'd12, 32'(cycles_done));
        stop_xfer();
    endtask

    task automatic read_from_memory();
        test_name = "memory to peripheral";
        for (int i = 0; i < 10; i++) begin
            mem[i] = rand_bits(32);
        end
        start_xfer(1'b1, 32'h0, 16'd10);
        pop_words(0, 10);
        wait_done();
        check_eq(test_name, 32'h0, 32'(remaining));
        check_eq(test_name, 32'h1, 32'(bgack_));
        stop_xfer();
    endtask

    task automatic hold_off_reads();
        test_name = "back-pressure";
        for (int i = 48; i < 58; i++) begin
            mem[i] = rand_bits(32);
        end
        start_xfer(1'b1, 32'hC0, 16'd10);
        @(negedge BBCLK);
        while (!fifo_full) @(negedge BBCLK);
        // no bus cycle while the peripheral holds off on a full FIFO
        repeat (12) begin
            @(negedge BBCLK);
            check_eq(test_name, 32'h3, 32'({fifo_full, bus_o.as_}));
        end
        pop_words(48, 10);
        wait_done();
        check_eq(test_name, 32'h0, 32'(remaining));
        stop_xfer();
    endtask

    task automatic flush_partial();
        test_name = "flush";
        stop_cnt  = 0;
        start_xfer(1'b0, 32'h80, 16'd20);
        for (int i = 0; i < 3; i++) begin
            words[i] = rand_bits(32);
            push_word(words[i]);
        end
        @(posedge BBCLK);
        flush <= 1'b1;
        @(posedge BBCLK);
        flush <= 1'b0;
        @(negedge BBCLK);
        while (stop_cnt == 0) @(negedge BBCLK);
        repeat (8) @(negedge BBCLK);
        check_eq(test_name, 32'd1, 32'(stop_cnt));
        for (int i = 0; i < 3; i++) begin
            check_eq(test_name, words[i], mem[32 + i]);
        end
        check_eq(test_name, fill_word(35), mem[35]);
        check_eq(test_name, 32'd17, 32'(remaining));
        check_eq(test_name, 32'h3, 32'({bgack_, breq_}));
        check_eq(test_name, 32'h0, 32'(done));
        stop_xfer();
    endtask

    initial begin
        CCRESET_  = 1'b0;
        cfg       = '0;
        dma_ena   = 1'b0;
        dreq_     = 1'b1;
        flush     = 1'b0;
        per_wr    = 1'b0;
        per_wdata = '0;
        per_rd    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        repeat (10) @(posedge BBCLK);
        CCRESET_ <= 1'b1;
        reset_defaults();
        write_to_memory();
        read_from_memory();
        hold_off_reads();
        flush_partial();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== build.f ====
hw/sdmac_pkg.sv
hw/xfer_counter.sv
hw/dma_fifo.sv
hw/cpu_sm.sv
hw/dma_top.sv
bench/dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module dma_tb \
    --Mdir obj_dir -o dma_sim > compile.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see compile.log"
    exit 1
fi

./obj_dir/dma_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
exit 0
